// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;		// data, address and instruction
	typedef logic [4:0]  reg_addr_t;	// register index
	typedef logic [5:0]  opcode_t;
	typedef logic [2:0]  alu_op_t;

	// opcode field values
	localparam opcode_t OP_ADD  = 6'h01;
	localparam opcode_t OP_SUB  = 6'h02;
	localparam opcode_t OP_MUL  = 6'h03;
	localparam opcode_t OP_AND  = 6'h04;
	localparam opcode_t OP_OR   = 6'h05;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_J    = 6'h10;
	localparam opcode_t OP_BEQ  = 6'h11;
	localparam opcode_t OP_LW   = 6'h23;
	localparam opcode_t OP_SW   = 6'h2B;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_MUL = 3'd2;
	localparam alu_op_t ALU_AND = 3'd3;
	localparam alu_op_t ALU_OR  = 3'd4;

	typedef struct packed {
		logic take;			// leave the pc+4 path
		logic is_branch;	// branch target, else jump target
	} pc_ctrl_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic    src_imm;	// operand b from immediate
		logic    dst_rd;	// write rd, else rt
	} ex_ctrl_t;

	typedef struct packed {
		logic cs;
		logic we;
	} mem_ctrl_t;

	typedef struct packed {
		logic from_mem;		// load data back to the register file
		logic reg_we;
	} wb_ctrl_t;

	// all-off values, also what an unknown opcode decodes to
	localparam pc_ctrl_t  PC_CTRL_NONE  = '{take: 1'b0, is_branch: 1'b0};
	localparam ex_ctrl_t  EX_CTRL_NONE  = '{alu_op: ALU_ADD, src_imm: 1'b0, dst_rd: 1'b0};
	localparam mem_ctrl_t MEM_CTRL_NONE = '{cs: 1'b0, we: 1'b0};
	localparam wb_ctrl_t  WB_CTRL_NONE  = '{from_mem: 1'b0, reg_we: 1'b0};

endpackage

// ==== logic/general_control.sv ====
`timescale 1ns/100ps

module general_control (
	input  cpu_pkg::opcode_t   op_i,
	input  logic               is_equal_i,
	output cpu_pkg::pc_ctrl_t  pc_ctrl_o,
	output cpu_pkg::ex_ctrl_t  ex_ctrl_o,
	output cpu_pkg::mem_ctrl_t mem_ctrl_o,
	output cpu_pkg::wb_ctrl_t  wb_ctrl_o
);

	always_comb
	begin
		pc_ctrl_o  = cpu_pkg::PC_CTRL_NONE;	// defaults cover unknown opcodes
		ex_ctrl_o  = cpu_pkg::EX_CTRL_NONE;
		mem_ctrl_o = cpu_pkg::MEM_CTRL_NONE;
		wb_ctrl_o  = cpu_pkg::WB_CTRL_NONE;

		case (op_i)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR:
			begin
				ex_ctrl_o.dst_rd = 1'b1;	// register format writes rd
				wb_ctrl_o.reg_we = 1'b1;
				case (op_i)
					cpu_pkg::OP_SUB: ex_ctrl_o.alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::OP_MUL: ex_ctrl_o.alu_op = cpu_pkg::ALU_MUL;
					cpu_pkg::OP_AND: ex_ctrl_o.alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OP_OR:  ex_ctrl_o.alu_op = cpu_pkg::ALU_OR;
					default:         ex_ctrl_o.alu_op = cpu_pkg::ALU_ADD;
				endcase
			end

			cpu_pkg::OP_ADDI:
			begin
				ex_ctrl_o.src_imm = 1'b1;
				wb_ctrl_o.reg_we  = 1'b1;	// into rt
			end

			cpu_pkg::OP_LW:
			begin
				ex_ctrl_o.src_imm  = 1'b1;	// base + offset
				mem_ctrl_o.cs      = 1'b1;
				wb_ctrl_o.from_mem = 1'b1;
				wb_ctrl_o.reg_we   = 1'b1;
			end

			cpu_pkg::OP_SW:
			begin
				ex_ctrl_o.src_imm = 1'b1;
				mem_ctrl_o.cs     = 1'b1;
				mem_ctrl_o.we     = 1'b1;	// no register write
			end

			cpu_pkg::OP_J:
			begin
				pc_ctrl_o.take = 1'b1;		// jump target
			end

			cpu_pkg::OP_BEQ:
			begin
				pc_ctrl_o.take      = is_equal_i;	// only on a taken branch
				pc_ctrl_o.is_branch = 1'b1;
			end

			default: ;	// all-off values stand
		endcase
	end

endmodule

// ==== logic/pc_unit.sv ====
`timescale 1ns/100ps

module pc_unit #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  cpu_pkg::pc_ctrl_t pc_ctrl_i,
	input  cpu_pkg::word_t    rs_data_i,
	input  cpu_pkg::word_t    rt_data_i,
	input  cpu_pkg::word_t    instr_i,
	output logic              is_equal_o,
	output cpu_pkg::word_t    pc_o
);

	cpu_pkg::word_t pc_q;
	cpu_pkg::word_t pc_plus4;
	cpu_pkg::word_t jump_target;
	cpu_pkg::word_t branch_target;
	cpu_pkg::word_t pc_next;

	assign is_equal_o    = (rs_data_i == rt_data_i);
	assign pc_plus4      = pc_q + 32'd4;
	assign jump_target   = {pc_plus4[31:28], instr_i[25:0], 2'b00};	// region of pc+4
	assign branch_target = pc_plus4 + {{14{instr_i[15]}}, instr_i[15:0], 2'b00};

	always_comb
	begin
		if (!pc_ctrl_i.take)
			pc_next = pc_plus4;
		else if (pc_ctrl_i.is_branch)
			pc_next = branch_target;
		else
			pc_next = jump_target;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			pc_q <= RESET_PC;
		else
			pc_q <= pc_next;
	end

	assign pc_o = pc_q;

	a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		pc_q[1:0] == 2'b00);

endmodule

// ==== logic/register_bank.sv ====
`timescale 1ns/100ps

module register_bank (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  cpu_pkg::word_t    instr_i,
	input  logic              dst_rd_i,
	input  cpu_pkg::wb_ctrl_t wb_ctrl_i,
	input  cpu_pkg::word_t    alu_result_i,
	input  cpu_pkg::word_t    mem_data_i,
	output cpu_pkg::word_t    rs_data_o,
	output cpu_pkg::word_t    rt_data_o
);

	cpu_pkg::word_t    regs [32];
	cpu_pkg::reg_addr_t rs_addr;
	cpu_pkg::reg_addr_t rt_addr;
	cpu_pkg::reg_addr_t rd_addr;
	cpu_pkg::reg_addr_t wr_addr;
	cpu_pkg::word_t    wr_data;

	assign rs_addr = instr_i[25:21];
	assign rt_addr = instr_i[20:16];
	assign rd_addr = instr_i[15:11];

	assign wr_addr = dst_rd_i ? rd_addr : rt_addr;
	assign wr_data = wb_ctrl_i.from_mem ? mem_data_i : alu_result_i;

	// asynchronous reads
	assign rs_data_o = regs[rs_addr];
	assign rt_data_o = regs[rt_addr];

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_ctrl_i.reg_we && wr_addr != 5'd0)	// r0 stays zero
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	a_r0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(rs_addr == 5'd0) |-> (rs_data_o == '0));

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
	input  cpu_pkg::ex_ctrl_t ex_ctrl_i,
	input  cpu_pkg::word_t    instr_i,
	input  cpu_pkg::word_t    rs_data_i,
	input  cpu_pkg::word_t    rt_data_i,
	output cpu_pkg::word_t    alu_result_o
);

	cpu_pkg::word_t imm_ext;
	cpu_pkg::word_t operand_b;
	cpu_pkg::word_t product;

	assign imm_ext   = {{16{instr_i[15]}}, instr_i[15:0]};
	assign operand_b = ex_ctrl_i.src_imm ? imm_ext : rt_data_i;
	assign product   = rs_data_i * operand_b;	// low 32 bits kept

	always_comb
	begin
		case (ex_ctrl_i.alu_op)
			cpu_pkg::ALU_ADD: alu_result_o = rs_data_i + operand_b;
			cpu_pkg::ALU_SUB: alu_result_o = rs_data_i - operand_b;
			cpu_pkg::ALU_MUL: alu_result_o = product;
			cpu_pkg::ALU_AND: alu_result_o = rs_data_i & operand_b;
			cpu_pkg::ALU_OR:  alu_result_o = rs_data_i | operand_b;
			default:          alu_result_o = '0;	// unused codes
		endcase
	end

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic           clk_i,
	input  logic           rst_n_i,
	output cpu_pkg::word_t imem_addr_o,
	input  cpu_pkg::word_t imem_data_i,
	output cpu_pkg::word_t dmem_addr_o,
	output cpu_pkg::word_t dmem_wdata_o,
	input  cpu_pkg::word_t dmem_rdata_i,
	output logic           dmem_cs_o,
	output logic           dmem_we_o
);

	cpu_pkg::pc_ctrl_t  pc_ctrl;
	cpu_pkg::ex_ctrl_t  ex_ctrl;
	cpu_pkg::mem_ctrl_t mem_ctrl;
	cpu_pkg::wb_ctrl_t  wb_ctrl;
	cpu_pkg::word_t     rs_data;
	cpu_pkg::word_t     rt_data;
	cpu_pkg::word_t     alu_result;
	logic               is_equal;

	general_control u_general_control (
		.op_i       (imem_data_i[31:26]),
		.is_equal_i (is_equal),
		.pc_ctrl_o  (pc_ctrl),
		.ex_ctrl_o  (ex_ctrl),
		.mem_ctrl_o (mem_ctrl),
		.wb_ctrl_o  (wb_ctrl)
	);

	pc_unit #(.RESET_PC(RESET_PC)) u_pc_unit (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.pc_ctrl_i  (pc_ctrl),
		.rs_data_i  (rs_data),
		.rt_data_i  (rt_data),
		.instr_i    (imem_data_i),
		.is_equal_o (is_equal),
		.pc_o       (imem_addr_o)
	);

	register_bank u_register_bank (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.instr_i      (imem_data_i),
		.dst_rd_i     (ex_ctrl.dst_rd),
		.wb_ctrl_i    (wb_ctrl),
		.alu_result_i (alu_result),
		.mem_data_i   (dmem_rdata_i),
		.rs_data_o    (rs_data),
		.rt_data_o    (rt_data)
	);

	execute_unit u_execute_unit (
		.ex_ctrl_i    (ex_ctrl),
		.instr_i      (imem_data_i),
		.rs_data_i    (rs_data),
		.rt_data_i    (rt_data),
		.alu_result_o (alu_result)
	);

	assign dmem_addr_o  = alu_result;	// base + offset
	assign dmem_wdata_o = rt_data;
	assign dmem_cs_o    = mem_ctrl.cs & rst_n_i;	// no access while in reset
	assign dmem_we_o    = mem_ctrl.we & rst_n_i;

	a_we_needs_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dmem_we_o |-> dmem_cs_o);

endmodule

// ==== tb/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic cpu_pkg::word_t fill_word(logic [7:0] idx);
	return {24'hA5A55A, idx};	// marks a word never written
endfunction

function automatic cpu_pkg::word_t sext16(logic [15:0] v);
	return {{16{v[15]}}, v};
endfunction

function automatic cpu_pkg::word_t reg_instr(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rs,
	cpu_pkg::reg_addr_t rt, cpu_pkg::reg_addr_t rd);
	return {op, rs, rt, rd, 11'd0};
endfunction

function automatic cpu_pkg::word_t imm_instr(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rs,
	cpu_pkg::reg_addr_t rt, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic cpu_pkg::word_t jump_instr(logic [25:0] target);
	return {cpu_pkg::OP_J, target};
endfunction

task automatic load_program;
	for (int i = 0; i < 32; i++)
		imem[i] = (i < prog.size()) ? prog[i] : '0;
	for (int i = 0; i < 256; i++)
		dmem[i] <= fill_word(i[7:0]);
	prog.delete();
endtask

// program goes in while the core is held in reset
task automatic reset_and_load;
	@(negedge clk_i);
	rst_n_i = 1'b0;
	load_program;
	repeat (5) @(negedge clk_i);
	rst_n_i = 1'b1;
endtask

task automatic run_cycles(int n);
	repeat (n) @(negedge clk_i);
endtask

task automatic compare_word(string name, cpu_pkg::word_t actual, cpu_pkg::word_t expected);
	if (actual !== expected)
	begin
		$display("Fail %s: got %h, expected %h", name, actual, expected);
		error_count++;
	end
endtask

task automatic compare_bit(string name, logic actual, logic expected);
	if (actual !== expected)
	begin
		$display("Fail %s: got %h, expected %h", name, actual, expected);
		error_count++;
	end
endtask

task automatic report_test(string name, int errors_before);
	if (error_count == errors_before)
	begin
		$display("%s: ok", name);
		pass_count++;
	end
	else
	begin
		$display("%s: %0d mismatches", name, error_count - errors_before);
		fail_count++;
	end
endtask

task automatic test_reset;
	int errors_before;
	errors_before = error_count;
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'd120));	// store at the reset address
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd124));
	@(negedge clk_i);
	rst_n_i = 1'b0;
	load_program;
	repeat (2) @(negedge clk_i);
	compare_word("imem_addr_o", imem_addr_o, RESET_PC);
	compare_bit("dmem_cs_o", dmem_cs_o, 1'b0);
	compare_bit("dmem_we_o", dmem_we_o, 1'b0);
	compare_word("dmem[30]", dmem[30], fill_word(8'd30));
	repeat (3) @(negedge clk_i);
	rst_n_i = 1'b1;
	#2;	// first cycle out of reset
	compare_word("imem_addr_o", imem_addr_o, RESET_PC);
	run_cycles(3);
	compare_word("dmem[30]", dmem[30], 32'd0);
	compare_word("dmem[31]", dmem[31], 32'd5);
	report_test("reset", errors_before);
endtask

task automatic test_arith;
	int             errors_before;
	logic [31:0]    rnd;
	logic [15:0]    ia;
	logic [15:0]    ib;
	cpu_pkg::word_t a;
	cpu_pkg::word_t b;
	errors_before = error_count;
	rnd = $random(seed);
	ia  = rnd[15:0];
	rnd = $random(seed);
	ib  = rnd[15:0];
	a   = sext16(ia);
	b   = sext16(ib);
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, ia));
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd2, ib));
	prog.push_back(reg_instr(cpu_pkg::OP_ADD, 5'd1, 5'd2, 5'd3));
	prog.push_back(reg_instr(cpu_pkg::OP_SUB, 5'd1, 5'd2, 5'd4));
	prog.push_back(reg_instr(cpu_pkg::OP_MUL, 5'd1, 5'd2, 5'd5));
	prog.push_back(reg_instr(cpu_pkg::OP_AND, 5'd1, 5'd2, 5'd6));
	prog.push_back(reg_instr(cpu_pkg::OP_OR, 5'd1, 5'd2, 5'd7));
	for (int r = 3; r <= 7; r++)
		prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, r[4:0], 16'((r - 3) * 4)));
	reset_and_load;
	run_cycles(12);
	compare_word("dmem[0] add", dmem[0], a + b);
	compare_word("dmem[1] sub", dmem[1], a - b);
	compare_word("dmem[2] mul", dmem[2], a * b);
	compare_word("dmem[3] and", dmem[3], a & b);
	compare_word("dmem[4] or", dmem[4], a | b);
	report_test("arith", errors_before);
endtask

task automatic test_load_store;
	int          errors_before;
	logic [31:0] rnd;
	errors_before = error_count;
	rnd = $random(seed);
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, rnd[15:0]));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd32));
	prog.push_back(imm_instr(cpu_pkg::OP_LW, 5'd0, 5'd2, 16'd32));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd2, 16'd36));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd0, 16'd40));	// r0 as source
	reset_and_load;
	run_cycles(1);
	compare_word("dmem_addr_o", dmem_addr_o, 32'd32);	// first store on the bus
	compare_word("dmem_wdata_o", dmem_wdata_o, sext16(rnd[15:0]));
	compare_bit("dmem_we_o", dmem_we_o, 1'b1);
	run_cycles(4);
	compare_word("dmem[8]", dmem[8], sext16(rnd[15:0]));
	compare_word("dmem[9]", dmem[9], sext16(rnd[15:0]));
	compare_word("dmem[10]", dmem[10], 32'd0);
	report_test("load_store", errors_before);
endtask

task automatic test_branch;
	int errors_before;
	errors_before = error_count;
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'd7));
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd2, 16'd7));
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd3, 16'd9));
	prog.push_back(imm_instr(cpu_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));	// taken
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd64));
	prog.push_back(imm_instr(cpu_pkg::OP_BEQ, 5'd1, 5'd3, 16'd1));	// not taken
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd3, 16'd68));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd2, 16'd72));
	reset_and_load;
	run_cycles(7);
	compare_word("dmem[16]", dmem[16], fill_word(8'd16));
	compare_word("dmem[17]", dmem[17], 32'd9);
	compare_word("dmem[18]", dmem[18], 32'd7);
	report_test("branch", errors_before);
endtask

task automatic test_jump;
	int             errors_before;
	cpu_pkg::word_t land;
	cpu_pkg::word_t pc_plus4;
	errors_before = error_count;
	land     = RESET_PC + 32'd12;	// fourth instruction
	pc_plus4 = RESET_PC + 32'd8;	// J sits at the second slot
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'd3));
	prog.push_back(jump_instr(land[27:2]));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd80));
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd84));
	reset_and_load;
	run_cycles(2);
	compare_word("imem_addr_o", imem_addr_o, {pc_plus4[31:28], land[27:2], 2'b00});
	run_cycles(1);
	compare_word("dmem[20]", dmem[20], fill_word(8'd20));
	compare_word("dmem[21]", dmem[21], 32'd3);
	report_test("jump", errors_before);
endtask

task automatic test_unknown_op;
	int          errors_before;
	logic [31:0] rnd;
	errors_before = error_count;
	rnd = $random(seed);
	prog.push_back(imm_instr(cpu_pkg::OP_ADDI, 5'd0, 5'd1, rnd[15:0]));
	prog.push_back(imm_instr(6'h3F, 5'd0, 5'd1, 16'h0060));	// undefined opcode
	prog.push_back(imm_instr(cpu_pkg::OP_SW, 5'd0, 5'd1, 16'd100));
	reset_and_load;
	run_cycles(1);
	compare_word("imem_addr_o", imem_addr_o, RESET_PC + 32'd4);
	compare_bit("dmem_cs_o", dmem_cs_o, 1'b0);
	compare_bit("dmem_we_o", dmem_we_o, 1'b0);
	run_cycles(1);
	compare_word("imem_addr_o", imem_addr_o, RESET_PC + 32'd8);
	run_cycles(1);
	compare_word("dmem[24]", dmem[24], fill_word(8'd24));
	compare_word("dmem[25]", dmem[25], sext16(rnd[15:0]));
	report_test("unknown_op", errors_before);
endtask

`endif

// ==== tb/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;

	localparam cpu_pkg::word_t RESET_PC    = 32'h0000_0100;
	localparam int             CLK_PERIOD  = 10;
	localparam int             TOTAL_INSTR = 35;	// sum of the program lengths
	localparam int             TEST_COUNT  = 6;
	localparam int             WATCHDOG_NS = (TOTAL_INSTR + TEST_COUNT * 8 + 40) * CLK_PERIOD;
	localparam cpu_pkg::word_t IMEM_BYTES  = 32'd128;	// 32 instruction words

	logic           clk_i;
	logic           rst_n_i;
	cpu_pkg::word_t imem_addr_o;
	cpu_pkg::word_t imem_data_i;
	cpu_pkg::word_t dmem_addr_o;
	cpu_pkg::word_t dmem_wdata_o;
	cpu_pkg::word_t dmem_rdata_i;
	logic           dmem_cs_o;
	logic           dmem_we_o;

	cpu_pkg::word_t imem [32];
	cpu_pkg::word_t dmem [256];
	cpu_pkg::word_t prog [$];	// program under construction
	cpu_pkg::word_t imem_offset;

	int seed        = 57;
	int error_count = 0;
	int pass_count  = 0;
	int fail_count  = 0;

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// instruction memory starts at the reset address, zero words elsewhere
	assign imem_offset  = imem_addr_o - RESET_PC;
	assign imem_data_i  = (imem_offset < IMEM_BYTES) ? imem[imem_offset[6:2]] : '0;
	assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];	// zero latency read

	always @(posedge clk_i)
	begin
		if (dmem_cs_o && dmem_we_o)
			dmem[dmem_addr_o[9:2]] <= dmem_wdata_o;
	end

	cpu_core #(.RESET_PC(RESET_PC)) dut0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.imem_addr_o  (imem_addr_o),
		.imem_data_i  (imem_data_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_cs_o    (dmem_cs_o),
		.dmem_we_o    (dmem_we_o)
	);

	`include "tb_tasks.svh"

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

	initial
	begin
		clk_i   = 1'b0;
		rst_n_i = 1'b0;
		load_program;	// empty program, fills both memories
		test_reset;
		test_arith;
		test_load_store;
		test_branch;
		test_jump;
		test_unknown_op;
		$display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
		if (error_count == 0)
		begin
			$display("test passed");
		end
		else
		begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+tb
logic/cpu_pkg.sv
logic/general_control.sv
logic/pc_unit.sv
logic/register_bank.sv
logic/execute_unit.sv
logic/cpu_core.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP        = tb_cpu
RTL_TOP    = cpu_core
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
SIM        = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
